// ==== loader_config.svh ====
// Loader build constants
`ifndef LOADER_CONFIG_SVH
`define LOADER_CONFIG_SVH

// ============================================================
// Memory map and download stream widths
// ============================================================

// Full memory map address
`define LDR_ADDR_W 25

// One memory byte
`define LDR_DATA_W 8

// Offset inside a downloaded file
`define LDR_DL_ADDR_W 16

// Download index code
`define LDR_INDEX_W 8

// ============================================================
// Load targets and erase pacing
// ============================================================

// ROM windows fed by the decoder
`define LDR_NWIN 6

// Pacing counter, one erase write per 2**width cycles
`define LDR_ERASE_PACE_W 5

`endif

// ==== loader_pkg.sv ====
// Loader types and window table
`include "loader_config.svh"

package loader_pkg;

	// Download index codes
	typedef enum logic [`LDR_INDEX_W-1:0] {
		TGT_P500    = `LDR_INDEX_W'd1,
		TGT_B6X0    = `LDR_INDEX_W'd2,
		TGT_B7X0    = `LDR_INDEX_W'd3,
		TGT_EXT2000 = `LDR_INDEX_W'd4,
		TGT_EXT4000 = `LDR_INDEX_W'd5,
		TGT_EXT6000 = `LDR_INDEX_W'd6
	} load_target_e;

	// Erase walk phases
	typedef enum logic [1:0] {
		ERASE_IDLE,
		ERASE_RAM,
		ERASE_SEG15,
		ERASE_VIDEO
	} erase_state_e;

	// One ROM window
	typedef struct packed {
		load_target_e              target;
		logic [`LDR_ADDR_W-1:0]    base;
		logic [`LDR_DL_ADDR_W:0]   length;
		logic                      chrgen_en;
		logic                      present_en;
	} win_cfg_t;

	// System ROMs first, then the three segment-15 cartridge slots
	localparam win_cfg_t WIN_TABLE [`LDR_NWIN] = '{
		'{TGT_P500,    25'h102_0000, 17'h0_B000, 1'b0, 1'b0},
		'{TGT_B6X0,    25'h100_0000, 17'h0_B000, 1'b1, 1'b0},
		'{TGT_B7X0,    25'h101_0000, 17'h0_B000, 1'b1, 1'b0},
		'{TGT_EXT2000, 25'h103_2000, 17'h0_2000, 1'b0, 1'b1},
		'{TGT_EXT4000, 25'h103_4000, 17'h0_2000, 1'b0, 1'b1},
		'{TGT_EXT6000, 25'h103_6000, 17'h0_2000, 1'b0, 1'b1}
	};

endpackage

// ==== load_decoder.sv ====
// Download strobe decoder
`timescale 1ns/1ps
`include "loader_config.svh"

module load_decoder
	import loader_pkg::*;
(
	input  logic                       clk_sys,
	input  logic                       arst_n_i,
	input  logic                       dl_wr_i,
	input  load_target_e               dl_index_i,
	input  logic [`LDR_DL_ADDR_W-1:0]  dl_addr_i,
	input  logic [`LDR_DATA_W-1:0]     dl_data_i,
	input  logic                       erase_busy_i,
	output logic                       dec_wr_o,
	output load_target_e               dec_index_o,
	output logic [`LDR_DL_ADDR_W-1:0]  dec_addr_o,
	output logic [`LDR_DATA_W-1:0]     dec_data_o
);

	// Strobe qualifier, downloads are lost while RAM is being cleared
	logic accept;

	assign accept = dl_wr_i && !erase_busy_i;

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dec_wr_o <= 1'b0;
		end else begin
			dec_wr_o <= accept;
		end
	end

	// Fields follow the stream every cycle
	always_ff @(posedge clk_sys) begin
		dec_index_o <= dl_index_i;
		dec_addr_o  <= dl_addr_i;
		dec_data_o  <= dl_data_i;
	end

endmodule

// ==== rom_window.sv ====
// ROM load window
`timescale 1ns/1ps
`include "loader_config.svh"

module rom_window
	import loader_pkg::*;
#(
	parameter int WIN = 0
) (
	input  logic                       clk_sys,
	input  logic                       arst_n_i,
	input  logic                       dec_wr_i,
	input  load_target_e               dec_index_i,
	input  logic [`LDR_DL_ADDR_W-1:0]  dec_addr_i,
	input  logic [`LDR_DATA_W-1:0]     dec_data_i,
	output logic                       win_we_o,
	output logic [`LDR_ADDR_W-1:0]     win_addr_o,
	output logic [`LDR_DATA_W-1:0]     win_data_o,
	output logic                       win_chr_o,
	output logic                       present_o
);

	localparam win_cfg_t CFG = WIN_TABLE[WIN];

	logic hit;
	logic in_range;
	logic chr_page;

	assign hit      = dec_wr_i && (dec_index_i == CFG.target);
	assign in_range = {1'b0, dec_addr_i} < CFG.length;

	// Character generator lives in the 0xA000 page of the B-series ROM
	assign chr_page = dec_addr_i[`LDR_DL_ADDR_W-1 -: 4] == 4'hA;

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			win_we_o  <= 1'b0;
			win_chr_o <= 1'b0;
			present_o <= 1'b0;
		end else begin
			win_we_o  <= hit && in_range;
			win_chr_o <= hit && in_range && CFG.chrgen_en && chr_page;
			// Sticky, an oversized image still marks the slot as fitted
			if (hit && CFG.present_en)
				present_o <= 1'b1;
		end
	end

	// Base plus offset into the memory map
	always_ff @(posedge clk_sys) begin
		win_addr_o <= CFG.base
			+ {{(`LDR_ADDR_W-`LDR_DL_ADDR_W){1'b0}}, dec_addr_i};
		win_data_o <= dec_data_i;
	end

endmodule

// ==== ram_eraser.sv ====
// Paced RAM erase sequencer
`timescale 1ns/1ps
`include "loader_config.svh"

module ram_eraser
	import loader_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    arst_n_i,
	input  logic                    erase_start_i,
	input  logic                    erase_full_i,
	input  logic                    erase_cancel_i,
	input  logic                    model_b_i,
	input  logic                    ram_256k_i,
	output logic                    er_we_o,
	output logic [`LDR_ADDR_W-1:0]  er_addr_o,
	output logic [`LDR_DATA_W-1:0]  er_data_o,
	output logic                    erase_busy_o
);

	// ============================================================
	// Walk boundaries
	// ============================================================

	localparam logic [`LDR_ADDR_W-1:0] P_START     = `LDR_ADDR_W'h0_0000;
	localparam logic [`LDR_ADDR_W-1:0] B_START     = `LDR_ADDR_W'h1_0000;
	localparam logic [`LDR_ADDR_W-1:0] SEG15_START = `LDR_ADDR_W'hF_0000;
	localparam logic [`LDR_ADDR_W-1:0] LOW_END     = `LDR_ADDR_W'hF_0FFF;
	localparam logic [`LDR_ADDR_W-1:0] VIDEO_START = `LDR_ADDR_W'hF_D000;
	localparam logic [`LDR_ADDR_W-1:0] SEG15_END   = `LDR_ADDR_W'hF_D7FF;

	erase_state_e                  state_q;
	erase_state_e                  step_state;
	logic [`LDR_ERASE_PACE_W-1:0]  pace_q;
	logic [`LDR_ADDR_W-1:0]        walk_addr;
	logic [`LDR_ADDR_W-1:0]        step_addr;
	logic [`LDR_ADDR_W-1:0]        ram_end;
	logic [`LDR_ADDR_W-1:0]        ram_end_sel;
	logic                          full_q;
	logic                          start_ok;
	logic                          fire;

	assign start_ok = erase_start_i && !erase_busy_o && !erase_cancel_i;
	assign fire     = (state_q != ERASE_IDLE) && (&pace_q) && !erase_cancel_i;

	// Top of RAM for the selected model and size
	always_comb begin
		case ({model_b_i, ram_256k_i})
			2'b00:   ram_end_sel = `LDR_ADDR_W'h1_FFFF;
			2'b01:   ram_end_sel = `LDR_ADDR_W'h3_FFFF;
			2'b10:   ram_end_sel = `LDR_ADDR_W'h2_FFFF;
			default: ram_end_sel = `LDR_ADDR_W'h4_FFFF;
		endcase
	end

	// Where the walk goes after the current byte
	always_comb begin
		step_state = state_q;
		step_addr  = walk_addr + 1'b1;
		case (state_q)
			ERASE_RAM: begin
				if (walk_addr == ram_end) begin
					step_state = ERASE_SEG15;
					step_addr  = SEG15_START;
				end
			end
			ERASE_SEG15: begin
				if (full_q && walk_addr == SEG15_END) begin
					step_state = ERASE_IDLE;
				end else if (!full_q && walk_addr == LOW_END) begin
					// Partial erase skips straight to video RAM
					step_state = ERASE_VIDEO;
					step_addr  = VIDEO_START;
				end
			end
			ERASE_VIDEO: begin
				if (walk_addr == SEG15_END)
					step_state = ERASE_IDLE;
			end
			default: ;
		endcase
	end

	// ============================================================
	// Control
	// ============================================================

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q      <= ERASE_IDLE;
			pace_q       <= '0;
			er_we_o      <= 1'b0;
			erase_busy_o <= 1'b0;
		end else begin
			er_we_o <= fire;
			if (erase_cancel_i) begin
				state_q      <= ERASE_IDLE;
				erase_busy_o <= 1'b0;
			end else if (start_ok) begin
				state_q      <= erase_full_i ? ERASE_RAM : ERASE_SEG15;
				pace_q       <= '0;
				erase_busy_o <= 1'b1;
			end else begin
				if (state_q != ERASE_IDLE)
					pace_q <= pace_q + 1'b1;
				if (fire)
					state_q <= step_state;
				// Busy drops one edge after the final write
				if (state_q == ERASE_IDLE)
					erase_busy_o <= 1'b0;
			end
		end
	end

	// ============================================================
	// Walk address and fill pattern
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (start_ok) begin
			full_q    <= erase_full_i;
			ram_end   <= ram_end_sel;
			walk_addr <= erase_full_i ? (model_b_i ? B_START : P_START) : SEG15_START;
		end else if (fire) begin
			walk_addr <= step_addr;
		end
		if (fire) begin
			er_addr_o <= walk_addr;
			er_data_o <= {`LDR_DATA_W{walk_addr[14] ^ walk_addr[3] ^ walk_addr[2]}};
		end
	end

endmodule

// ==== mem_write_arbiter.sv ====
// Memory write merge
`timescale 1ns/1ps
`include "loader_config.svh"

module mem_write_arbiter (
	input  logic                    clk_sys,
	input  logic                    arst_n_i,
	input  logic [`LDR_NWIN-1:0]    win_we_i,
	input  logic [`LDR_ADDR_W-1:0]  win_addr_i [`LDR_NWIN],
	input  logic [`LDR_DATA_W-1:0]  win_data_i [`LDR_NWIN],
	input  logic [`LDR_NWIN-1:0]    win_chr_i,
	input  logic                    er_we_i,
	input  logic [`LDR_ADDR_W-1:0]  er_addr_i,
	input  logic [`LDR_DATA_W-1:0]  er_data_i,
	output logic                    mem_we_o,
	output logic [`LDR_ADDR_W-1:0]  mem_addr_o,
	output logic [`LDR_DATA_W-1:0]  mem_data_o,
	output logic                    chrgen_wr_o
);

	logic                    any_win;
	logic                    sel_chr;
	logic [`LDR_ADDR_W-1:0]  sel_addr;
	logic [`LDR_DATA_W-1:0]  sel_data;

	assign any_win = |win_we_i;

	// Windows are one-hot by index, the eraser fills in when all are idle
	always_comb begin
		sel_addr = er_addr_i;
		sel_data = er_data_i;
		sel_chr  = 1'b0;
		for (int i = 0; i < `LDR_NWIN; i++) begin
			if (win_we_i[i]) begin
				sel_addr = win_addr_i[i];
				sel_data = win_data_i[i];
				sel_chr  = win_chr_i[i];
			end
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mem_we_o    <= 1'b0;
			chrgen_wr_o <= 1'b0;
		end else begin
			mem_we_o    <= any_win || er_we_i;
			chrgen_wr_o <= any_win && sel_chr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (any_win || er_we_i) begin
			mem_addr_o <= sel_addr;
			mem_data_o <= sel_data;
		end
	end

endmodule

// ==== cbm2_loader.sv ====
// CBM-II memory loader top
`timescale 1ns/1ps
`include "loader_config.svh"

module cbm2_loader
	import loader_pkg::*;
(
	input  logic                       clk_sys,
	input  logic                       arst_n_i,
	input  logic                       dl_wr_i,
	input  load_target_e               dl_index_i,
	input  logic [`LDR_DL_ADDR_W-1:0]  dl_addr_i,
	input  logic [`LDR_DATA_W-1:0]     dl_data_i,
	input  logic                       erase_start_i,
	input  logic                       erase_full_i,
	input  logic                       erase_cancel_i,
	input  logic                       model_b_i,
	input  logic                       ram_256k_i,
	output logic                       mem_we_o,
	output logic [`LDR_ADDR_W-1:0]     mem_addr_o,
	output logic [`LDR_DATA_W-1:0]     mem_data_o,
	output logic                       chrgen_wr_o,
	output logic [2:0]                 ext_rom_o,
	output logic                       erase_busy_o
);

	// Cartridge slots are the last three table entries
	localparam int EXT_FIRST = `LDR_NWIN - 3;

	// ============================================================
	// Decoder broadcast
	// ============================================================

	logic                       dec_wr;
	load_target_e               dec_index;
	logic [`LDR_DL_ADDR_W-1:0]  dec_addr;
	logic [`LDR_DATA_W-1:0]     dec_data;

	load_decoder u_decoder (
		.clk_sys      (clk_sys),
		.arst_n_i     (arst_n_i),
		.dl_wr_i      (dl_wr_i),
		.dl_index_i   (dl_index_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.erase_busy_i (erase_busy_o),
		.dec_wr_o     (dec_wr),
		.dec_index_o  (dec_index),
		.dec_addr_o   (dec_addr),
		.dec_data_o   (dec_data)
	);

	// ============================================================
	// ROM windows
	// ============================================================

	logic [`LDR_NWIN-1:0]    win_we;
	logic [`LDR_ADDR_W-1:0]  win_addr [`LDR_NWIN];
	logic [`LDR_DATA_W-1:0]  win_data [`LDR_NWIN];
	logic [`LDR_NWIN-1:0]    win_chr;
	logic [`LDR_NWIN-1:0]    win_present;

	for (genvar g = 0; g < `LDR_NWIN; g++) begin : g_win
		rom_window #(
			.WIN (g)
		) u_win (
			.clk_sys     (clk_sys),
			.arst_n_i    (arst_n_i),
			.dec_wr_i    (dec_wr),
			.dec_index_i (dec_index),
			.dec_addr_i  (dec_addr),
			.dec_data_i  (dec_data),
			.win_we_o    (win_we[g]),
			.win_addr_o  (win_addr[g]),
			.win_data_o  (win_data[g]),
			.win_chr_o   (win_chr[g]),
			.present_o   (win_present[g])
		);
	end

	assign ext_rom_o = win_present[`LDR_NWIN-1:EXT_FIRST];

	// ============================================================
	// Eraser and write merge
	// ============================================================

	logic                    er_we;
	logic [`LDR_ADDR_W-1:0]  er_addr;
	logic [`LDR_DATA_W-1:0]  er_data;

	ram_eraser u_eraser (
		.clk_sys        (clk_sys),
		.arst_n_i       (arst_n_i),
		.erase_start_i  (erase_start_i),
		.erase_full_i   (erase_full_i),
		.erase_cancel_i (erase_cancel_i),
		.model_b_i      (model_b_i),
		.ram_256k_i     (ram_256k_i),
		.er_we_o        (er_we),
		.er_addr_o      (er_addr),
		.er_data_o      (er_data),
		.erase_busy_o   (erase_busy_o)
	);

	mem_write_arbiter u_arbiter (
		.clk_sys     (clk_sys),
		.arst_n_i    (arst_n_i),
		.win_we_i    (win_we),
		.win_addr_i  (win_addr),
		.win_data_i  (win_data),
		.win_chr_i   (win_chr),
		.er_we_i     (er_we),
		.er_addr_i   (er_addr),
		.er_data_i   (er_data),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o),
		.chrgen_wr_o (chrgen_wr_o)
	);

endmodule

// ==== loader_asserts.sv ====
// Arbiter write assertions
`timescale 1ns/1ps
`include "loader_config.svh"

module loader_asserts (
	input logic                     clk_sys,
	input logic                     arst_n_i,
	input logic [`LDR_NWIN-1:0]     win_we_i,
	input logic                     er_we_i,
	input logic                     mem_we_i,
	input logic [`LDR_ADDR_W-1:0]   mem_addr_i,
	input logic                     chrgen_wr_i
);

	a_one_window: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		$onehot0(win_we_i)) else $error("more than one ROM window wrote in one cycle");

	a_no_overlap: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		!((|win_we_i) && er_we_i)) else $error("window write met an erase write");

	// Character ROM bytes sit in the 0xA000 page of the B6x0 and B7x0 images
	a_chr_with_we: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		chrgen_wr_i |-> mem_we_i && mem_addr_i[24:17] == 8'h80 && mem_addr_i[15:12] == 4'hA)
		else $error("chrgen strobe outside a B-series character ROM write");

endmodule

bind mem_write_arbiter loader_asserts u_asserts (
	.clk_sys     (clk_sys),
	.arst_n_i    (arst_n_i),
	.win_we_i    (win_we_i),
	.er_we_i     (er_we_i),
	.mem_we_i    (mem_we_o),
	.mem_addr_i  (mem_addr_o),
	.chrgen_wr_i (chrgen_wr_o)
);

// ==== loader_checker.sv ====
// Loader write checker
`timescale 1ns/1ps

module loader_checker (
	input  logic         clk_sys,
	input  logic         arst_n_i,
	input  logic         dl_wr_i,
	input  logic [7:0]   dl_index_i,
	input  logic [15:0]  dl_addr_i,
	input  logic         erase_start_i,
	input  logic         erase_full_i,
	input  logic         erase_cancel_i,
	input  logic         model_b_i,
	input  logic         ram_256k_i,
	input  logic [7:0]   dl_data_i,
	input  logic         mem_we_i,
	input  logic [24:0]  mem_addr_i,
	input  logic [7:0]   mem_data_i,
	input  logic         chrgen_wr_i,
	input  logic [2:0]   ext_rom_i,
	input  logic         erase_busy_i,
	input  logic         test_end_i,
	input  int           test_id_i,
	input  int           exp_count_i,
	output int           tests_o,
	output int           failed_o,
	output int           errors_o
);

	int          cyc;
	int          wr_cnt;
	int          err_mark;
	int          q_due [$];
	logic [24:0] q_addr [$];
	logic [7:0]  q_data [$];
	bit          q_chr [$];
	logic [2:0]  ext_exp;
	bit          er_on;
	bit          er_full;
	int          er_ph;
	int          er_next;
	logic [24:0] er_addr;
	logic [24:0] er_end;

	// Memory map rules for each download index
	function automatic bit win_rule(input logic [7:0] idx, output logic [24:0] base,
		output logic [16:0] len, output bit chr);
		chr = (idx == 8'd2) || (idx == 8'd3);
		len = (idx <= 8'd3) ? 17'h0B000 : 17'h02000;
		case (idx)
			8'd1: base = 25'h1020000;
			8'd2: base = 25'h1000000;
			8'd3: base = 25'h1010000;
			8'd4: base = 25'h1032000;
			8'd5: base = 25'h1034000;
			8'd6: base = 25'h1036000;
			default: base = '0;
		endcase
		return (idx >= 8'd1) && (idx <= 8'd6);
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got) begin
			$display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp, got);
			errors_o++;
		end
	endtask

	always @(posedge clk_sys) begin
		logic [24:0] base;
		logic [16:0] len;
		bit          chr;
		if (!arst_n_i) begin
			cyc = 0;
			wr_cnt = 0;
			err_mark = 0;
			ext_exp = '0;
			er_on = 0;
			tests_o = 0;
			failed_o = 0;
			errors_o = 0;
		end else begin
			cyc++;
			// ============================================================
			// Compare the write seen at this edge
			// ============================================================
			if (mem_we_i) begin
				wr_cnt++;
				if (q_due.size() > 0 && q_due[0] == cyc) begin
					check_val("mem_addr_o", 32'(q_addr[0]), 32'(mem_addr_i));
					check_val("mem_data_o", 32'(q_data[0]), 32'(mem_data_i));
					check_val("chrgen_wr_o", 32'(q_chr[0]), 32'(chrgen_wr_i));
					void'(q_due.pop_front());
					void'(q_addr.pop_front());
					void'(q_data.pop_front());
					void'(q_chr.pop_front());
				end else if (er_on && cyc == er_next) begin
					check_val("mem_addr_o", 32'(er_addr), 32'(mem_addr_i));
					check_val("mem_data_o", {24'h0, {8{er_addr[14] ^ er_addr[3] ^ er_addr[2]}}},
						32'(mem_data_i));
					check_val("chrgen_wr_o", 32'h0, 32'(chrgen_wr_i));
					er_next += 32;
					case (er_ph)
						0: if (er_addr == er_end) begin
							er_ph = 1;
							er_addr = 25'h0F0000;
						end else er_addr++;
						1: if (er_full && er_addr == 25'h0FD7FF) er_on = 0;
						else if (!er_full && er_addr == 25'h0F0FFF) begin
							er_ph = 2;
							er_addr = 25'h0FD000;
						end else er_addr++;
						default: if (er_addr == 25'h0FD7FF) er_on = 0;
						else er_addr++;
					endcase
				end else begin
					$display("t=%0t: memory write to %h that no load or erase explains",
						$time, mem_addr_i);
					errors_o++;
				end
			end else if (q_due.size() > 0 && q_due[0] == cyc) begin
				$display("t=%0t: expected load write to %h never appeared", $time, q_addr[0]);
				errors_o++;
				void'(q_due.pop_front());
				void'(q_addr.pop_front());
				void'(q_data.pop_front());
				void'(q_chr.pop_front());
			end else if (er_on && cyc == er_next) begin
				$display("t=%0t: expected erase write to %h never appeared", $time, er_addr);
				errors_o++;
				er_on = 0;
			end
			// ============================================================
			// Predict from the inputs sampled at this edge
			// ============================================================
			if (erase_cancel_i) begin
				er_on = 0;
			end else if (erase_start_i && !erase_busy_i) begin
				er_on = 1;
				er_full = erase_full_i;
				er_ph = erase_full_i ? 0 : 1;
				er_addr = !erase_full_i ? 25'h0F0000 : (model_b_i ? 25'h010000 : 25'h0);
				er_end = {6'h0, model_b_i ? (ram_256k_i ? 19'h4FFFF : 19'h2FFFF)
					: (ram_256k_i ? 19'h3FFFF : 19'h1FFFF)};
				er_next = cyc + 34;
			end
			if (dl_wr_i && !erase_busy_i && win_rule(dl_index_i, base, len, chr)) begin
				if (dl_index_i >= 8'd4)
					ext_exp[dl_index_i - 8'd4] = 1'b1;
				if ({1'b0, dl_addr_i} < len) begin
					q_due.push_back(cyc + 3);
					q_addr.push_back(base + {9'h0, dl_addr_i});
					q_data.push_back(dl_data_i);
					q_chr.push_back(chr && dl_addr_i[15:12] == 4'hA);
				end
			end
			if (test_end_i) begin
				check_val("write count", 32'(exp_count_i), 32'(wr_cnt));
				check_val("ext_rom_o", 32'(ext_exp), 32'(ext_rom_i));
				check_val("erase_busy_o", 32'h0, 32'(erase_busy_i));
				if (q_due.size() != 0) begin
					$display("t=%0t: predicted load writes still outstanding", $time);
					errors_o++;
				end
				tests_o++;
				if (errors_o != err_mark)
					failed_o++;
				$display("test %0d: %0d writes, expected %0d, %s", test_id_i, wr_cnt,
					exp_count_i, (errors_o == err_mark) ? "ok" : "FAILED");
				err_mark = errors_o;
				wr_cnt = 0;
			end
		end
	end

endmodule

// ==== tb_cbm2_loader.sv ====
// CBM-II loader testbench
`timescale 1ns/1ps
`include "loader_config.svh"

module tb_cbm2_loader
	import loader_pkg::*;
;

	localparam int OP_LOAD   = 0;
	localparam int OP_ERASE  = 1;
	localparam int OP_CANCEL = 2;
	localparam int NROWS     = 18;
	// Load rows, one partial erase, four cancelled erases, margin
	localparam int WD_CYCLES = NROWS * 400 + 6144 * 32 + 4000;

	typedef struct {
		int op;
		int idx;
		int off;
		bit full;
		bit mb;
		bit r256;
		int exp;
	} row_t;

	logic         clk_sys;
	logic         arst_n_i;
	logic         dl_wr_i;
	load_target_e dl_index_i;
	logic [15:0]  dl_addr_i;
	logic [7:0]   dl_data_i;
	logic         erase_start_i;
	logic         erase_full_i;
	logic         erase_cancel_i;
	logic         model_b_i;
	logic         ram_256k_i;
	logic         mem_we_o;
	logic [24:0]  mem_addr_o;
	logic [7:0]   mem_data_o;
	logic         chrgen_wr_o;
	logic [2:0]   ext_rom_o;
	logic         erase_busy_o;
	logic         test_end;
	int           test_id;
	int           exp_count;
	int           tests;
	int           failed;
	int           errors;
	logic [15:0]  lfsr;
	row_t         rows [NROWS];

	cbm2_loader DUT (.*);

	loader_checker u_checker (
		.clk_sys(clk_sys), .arst_n_i(arst_n_i), .dl_wr_i(dl_wr_i), .dl_index_i(dl_index_i),
		.dl_addr_i(dl_addr_i), .erase_start_i(erase_start_i), .erase_full_i(erase_full_i),
		.erase_cancel_i(erase_cancel_i), .model_b_i(model_b_i), .ram_256k_i(ram_256k_i),
		.dl_data_i(dl_data_i), .mem_we_i(mem_we_o), .mem_addr_i(mem_addr_o),
		.mem_data_i(mem_data_o), .chrgen_wr_i(chrgen_wr_o), .ext_rom_i(ext_rom_o),
		.erase_busy_i(erase_busy_o), .test_end_i(test_end), .test_id_i(test_id),
		.exp_count_i(exp_count), .tests_o(tests), .failed_o(failed), .errors_o(errors)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		#(WD_CYCLES * 100);
		$display("Timeout, the run did not finish in the allowed time");
		$display(">>> FAIL");
		$finish;
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic        lsb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb)
				lfsr = lfsr ^ 16'hB400;
			v = {v[30:0], lsb};
		end
		return v;
	endfunction

	initial begin
		logic [31:0] v;
		int          off;
		int          seen;
		lfsr = 16'd41;
		arst_n_i = 1'b0;
		dl_wr_i = 1'b0;
		dl_index_i = TGT_P500;
		dl_addr_i = '0;
		dl_data_i = '0;
		erase_start_i = 1'b0;
		erase_full_i = 1'b0;
		erase_cancel_i = 1'b0;
		model_b_i = 1'b0;
		ram_256k_i = 1'b0;
		test_end = 1'b0;
		test_id = 0;
		exp_count = 0;
		// Stimulus table, offset -1 means random in range
		rows[0] = '{OP_LOAD, 1, -1, 0, 0, 0, 3};
		rows[1] = '{OP_LOAD, 2, -1, 0, 0, 0, 3};
		rows[2] = '{OP_LOAD, 3, -1, 0, 0, 0, 3};
		rows[3] = '{OP_LOAD, 5, 'h2000, 0, 0, 0, 0};
		rows[4] = '{OP_LOAD, 4, -1, 0, 0, 0, 3};
		rows[5] = '{OP_LOAD, 5, -1, 0, 0, 0, 3};
		rows[6] = '{OP_LOAD, 6, -1, 0, 0, 0, 3};
		rows[7] = '{OP_LOAD, 2, 'hA010, 0, 0, 0, 3};
		rows[8] = '{OP_LOAD, 3, 'hAFF0, 0, 0, 0, 3};
		rows[9] = '{OP_LOAD, 1, 'hA000, 0, 0, 0, 3};
		rows[10] = '{OP_LOAD, 1, 'hB000, 0, 0, 0, 0};
		rows[11] = '{OP_LOAD, 6, 'h2FF0, 0, 0, 0, 0};
		rows[12] = '{OP_LOAD, 0, 0, 0, 0, 0, 0};
		rows[13] = '{OP_ERASE, 0, 0, 0, 0, 0, 6144};
		rows[14] = '{OP_CANCEL, 0, 0, 1, 0, 0, 4};
		rows[15] = '{OP_CANCEL, 0, 0, 1, 0, 1, 4};
		rows[16] = '{OP_CANCEL, 0, 0, 1, 1, 0, 4};
		rows[17] = '{OP_CANCEL, 0, 0, 1, 1, 1, 4};
		repeat (2) @(posedge clk_sys);
		arst_n_i <= 1'b1;
		repeat (2) @(posedge clk_sys);

		for (int r = 0; r < NROWS; r++) begin
			if (rows[r].op == OP_LOAD) begin
				off = rows[r].off;
				if (off < 0) begin
					v = take_bits(16);
					off = int'(v % ((rows[r].idx <= 3) ? 32'hAFFE : 32'h1FFE));
				end
				// Three back-to-back strobes
				for (int k = 0; k < 3; k++) begin
					@(posedge clk_sys);
					v = take_bits(8);
					dl_wr_i <= 1'b1;
					dl_index_i <= load_target_e'(8'(rows[r].idx));
					dl_addr_i <= 16'(off + k);
					dl_data_i <= v[7:0];
				end
				@(posedge clk_sys);
				dl_wr_i <= 1'b0;
				repeat (6) @(posedge clk_sys);
			end else begin
				@(posedge clk_sys);
				erase_start_i <= 1'b1;
				erase_full_i <= rows[r].full;
				model_b_i <= rows[r].mb;
				ram_256k_i <= rows[r].r256;
				@(posedge clk_sys);
				erase_start_i <= 1'b0;
				@(posedge clk_sys);
				while (!erase_busy_o)
					@(posedge clk_sys);
				// Dropped while busy
				dl_wr_i <= 1'b1;
				dl_index_i <= TGT_P500;
				dl_addr_i <= 16'h0010;
				@(posedge clk_sys);
				dl_wr_i <= 1'b0;
				if (rows[r].op == OP_ERASE) begin
					while (erase_busy_o)
						@(posedge clk_sys);
				end else begin
					seen = 0;
					while (seen < 4) begin
						@(posedge clk_sys);
						if (mem_we_o)
							seen++;
					end
					erase_cancel_i <= 1'b1;
					@(posedge clk_sys);
					erase_cancel_i <= 1'b0;
					repeat (80) @(posedge clk_sys);
				end
				repeat (4) @(posedge clk_sys);
			end
			test_end <= 1'b1;
			test_id <= r;
			exp_count <= rows[r].exp;
			@(posedge clk_sys);
			test_end <= 1'b0;
			repeat (2) @(posedge clk_sys);
		end

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0 && failed == 0 && tests == NROWS) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+.
loader_pkg.sv
load_decoder.sv
rom_window.sv
ram_eraser.sv
mem_write_arbiter.sv
cbm2_loader.sv
loader_asserts.sv
loader_checker.sv
tb_cbm2_loader.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator and run, pass only when the testbench reports it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_cbm2_loader -f all.f \
	&& ./obj_dir/Vtb_cbm2_loader | tee /dev/stderr | grep -qx ">>> PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
